// ==== Bender.yml ====
package:
  name: dcache_subsystem

sources:
  - hdl/dcache_pkg.sv
  - hdl/mem_bus_if.sv
  - hdl/dcache.sv
  - hdl/main_memory.sv
  - hdl/dcache_subsystem.sv
  - target: simulation
    files:
      - sim/dcache_checker.sv
      - sim/tb_dcache_subsystem.sv

// ==== dcache_subsystem.f ====
hdl/dcache_pkg.sv
hdl/mem_bus_if.sv
hdl/dcache.sv
hdl/main_memory.sv
hdl/dcache_subsystem.sv
sim/dcache_checker.sv
sim/tb_dcache_subsystem.sv

// ==== hdl/dcache.sv ====
module dcache #(
    parameter int NUM_SETS = 2
) (
    input logic clk,
    input logic reset,

    input dcache_pkg::addr_t addr,
    input dcache_pkg::word_t write_data,
    input logic read_en,
    input logic write_en,
    input dcache_pkg::funct3_t funct3,

    output dcache_pkg::word_t read_data,
    output logic busy,
    output logic hit,

    mem_bus_if.cache mem
);

    localparam int SET_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = dcache_pkg::ADDR_BITS - dcache_pkg::OFFSET_BITS - SET_BITS;

    typedef logic [SET_BITS-1:0] set_idx_t;
    typedef logic [TAG_BITS-1:0] tag_t;

    // Two ways per set
    dcache_pkg::line_t line_data [NUM_SETS][2];
    tag_t line_tag [NUM_SETS][2];
    logic line_valid [NUM_SETS][2];
    logic line_dirty [NUM_SETS][2];

    // Points at the way to replace next
    logic lru [NUM_SETS];

    dcache_pkg::cache_state_t state;
    logic victim;

    tag_t req_tag;
    set_idx_t req_set;
    dcache_pkg::word_sel_t word_sel;
    dcache_pkg::byte_sel_t byte_sel;

    logic req;
    logic [1:0] way_hit;
    logic lookup_hit;
    logic hit_way;

    dcache_pkg::line_t hit_line;
    dcache_pkg::word_t hit_word;
    dcache_pkg::word_t merged_word;
    logic [7:0] byte_val;
    logic [15:0] half_val;

    // Address fields
    assign req_tag = addr[dcache_pkg::ADDR_BITS-1 -: TAG_BITS];
    assign req_set = addr[dcache_pkg::OFFSET_BITS +: SET_BITS];
    assign word_sel = addr[dcache_pkg::BYTE_SEL_BITS +: dcache_pkg::WORD_SEL_BITS];
    assign byte_sel = addr[dcache_pkg::BYTE_SEL_BITS-1:0];

    assign req = read_en || write_en;

    // Both ways compared in parallel
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = line_valid[req_set][w] && (line_tag[req_set][w] == req_tag);
        end
    end

    assign lookup_hit = |way_hit;
    assign hit_way = way_hit[1];

    assign hit = req && lookup_hit;
    assign busy = req && !lookup_hit;

    assign hit_line = line_data[req_set][hit_way];
    assign hit_word = hit_line[word_sel * dcache_pkg::WORD_BITS +: dcache_pkg::WORD_BITS];
    assign byte_val = hit_word[byte_sel * 8 +: 8];
    assign half_val = hit_word[byte_sel[1] * 16 +: 16];

    // Load extraction with sign or zero extension
    always_comb begin
        case (funct3)
            dcache_pkg::F3_B: read_data = {{24{byte_val[7]}}, byte_val};
            dcache_pkg::F3_BU: read_data = {24'b0, byte_val};
            dcache_pkg::F3_H: read_data = {{16{half_val[15]}}, half_val};
            dcache_pkg::F3_HU: read_data = {16'b0, half_val};
            default: read_data = hit_word;
        endcase
    end

    // Store merge into the addressed word
    always_comb begin
        merged_word = hit_word;
        case (funct3)
            dcache_pkg::F3_B: merged_word[byte_sel * 8 +: 8] = write_data[7:0];
            dcache_pkg::F3_H: merged_word[byte_sel[1] * 16 +: 16] = write_data[15:0];
            default: merged_word = write_data;
        endcase
    end

    // Enables follow the FSM state, so they drop the cycle after ready
    assign mem.read_en = (state == dcache_pkg::REFILL);
    assign mem.write_en = (state == dcache_pkg::WRITE_BACK);
    assign mem.write_data = line_data[req_set][victim];
    assign mem.addr = (state == dcache_pkg::WRITE_BACK)
        ? {line_tag[req_set][victim], req_set, {dcache_pkg::OFFSET_BITS{1'b0}}}
        : {req_tag, req_set, {dcache_pkg::OFFSET_BITS{1'b0}}};

    // Control state and miss FSM
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dcache_pkg::IDLE;
            victim <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                lru[s] <= 1'b0;
                for (int w = 0; w < 2; w++) begin
                    line_valid[s][w] <= 1'b0;
                    line_dirty[s][w] <= 1'b0;
                end
            end
        end else begin
            case (state)
                dcache_pkg::IDLE: begin
                    if (req && !lookup_hit) begin
                        victim <= lru[req_set];
                        if (line_valid[req_set][lru[req_set]] &&
                            line_dirty[req_set][lru[req_set]]) begin
                            state <= dcache_pkg::WRITE_BACK;
                        end else begin
                            state <= dcache_pkg::REFILL;
                        end
                    end
                end
                dcache_pkg::WRITE_BACK: begin
                    if (mem.ready) begin
                        line_dirty[req_set][victim] <= 1'b0;
                        state <= dcache_pkg::REFILL;
                    end
                end
                dcache_pkg::REFILL: begin
                    if (mem.ready) begin
                        line_valid[req_set][victim] <= 1'b1;
                        state <= dcache_pkg::IDLE;
                    end
                end
                default: state <= dcache_pkg::IDLE;
            endcase

            // Hit bookkeeping; a refilled request lands here one cycle later
            if (req && lookup_hit) begin
                lru[req_set] <= ~hit_way;
                if (write_en) begin
                    line_dirty[req_set][hit_way] <= 1'b1;
                end
            end
        end
    end

    // Line payload and tags
    always_ff @(posedge clk) begin
        if (state == dcache_pkg::REFILL && mem.ready) begin
            line_data[req_set][victim] <= mem.read_data;
            line_tag[req_set][victim] <= req_tag;
        end else if (write_en && lookup_hit) begin
            line_data[req_set][hit_way][word_sel * dcache_pkg::WORD_BITS +: dcache_pkg::WORD_BITS]
                <= merged_word;
        end
    end

    // A bus request keeps its enables, address and data until ready
    a_bus_hold: assert property (
        @(posedge clk) disable iff (reset)
        ((mem.read_en || mem.write_en) && !mem.ready) |=>
            ($stable(mem.read_en) && $stable(mem.write_en) &&
             $stable(mem.addr) && $stable(mem.write_data))
    );

    // A miss in progress keeps the requester stalled
    a_busy_in_miss: assert property (
        @(posedge clk) disable iff (reset)
        (state != dcache_pkg::IDLE) |-> busy
    );

endmodule

// ==== hdl/dcache_pkg.sv ====
package dcache_pkg;

    localparam int WORD_BITS = 32;
    localparam int ADDR_BITS = 32;

    // One line is four words
    localparam int LINE_BYTES = 16;
    localparam int LINE_BITS = LINE_BYTES * 8;

    // Offset splits into word select and byte select
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int BYTE_SEL_BITS = 2;
    localparam int WORD_SEL_BITS = OFFSET_BITS - BYTE_SEL_BITS;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [WORD_SEL_BITS-1:0] word_sel_t;
    typedef logic [BYTE_SEL_BITS-1:0] byte_sel_t;

    // RISC-V load/store size codes
    typedef logic [2:0] funct3_t;
    localparam funct3_t F3_B = 3'd0;
    localparam funct3_t F3_H = 3'd1;
    localparam funct3_t F3_W = 3'd2;
    localparam funct3_t F3_BU = 3'd4;
    localparam funct3_t F3_HU = 3'd5;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_BACK,
        REFILL
    } cache_state_t;

    // Memory content of a word straight after reset
    localparam word_t INIT_PATTERN = 32'ha5a5_0000;

    function automatic word_t init_word(addr_t byte_addr);
        return byte_addr ^ INIT_PATTERN;
    endfunction

endpackage

// ==== hdl/dcache_subsystem.sv ====
module dcache_subsystem #(
    parameter int NUM_SETS = 2,
    parameter int MEM_LATENCY = 3,
    parameter int MEM_LINES = 64
) (
    input logic clk,
    input logic reset,

    input dcache_pkg::addr_t addr,
    input dcache_pkg::word_t write_data,
    input logic read_en,
    input logic write_en,
    input dcache_pkg::funct3_t funct3,

    output dcache_pkg::word_t read_data,
    output logic busy,
    output logic hit
);

    // Line bus between cache and memory
    mem_bus_if mem_bus ();

    dcache #(
        .NUM_SETS(NUM_SETS)
    ) dcache_i (
        .clk(clk),
        .reset(reset),
        .addr(addr),
        .write_data(write_data),
        .read_en(read_en),
        .write_en(write_en),
        .funct3(funct3),
        .read_data(read_data),
        .busy(busy),
        .hit(hit),
        .mem(mem_bus.cache)
    );

    main_memory #(
        .MEM_LATENCY(MEM_LATENCY),
        .MEM_LINES(MEM_LINES)
    ) main_memory_i (
        .clk(clk),
        .reset(reset),
        .bus(mem_bus.memory)
    );

endmodule

// ==== hdl/main_memory.sv ====
module main_memory #(
    parameter int MEM_LATENCY = 3,
    parameter int MEM_LINES = 64
) (
    input logic clk,
    input logic reset,
    mem_bus_if.memory bus
);

    localparam int INDEX_BITS = $clog2(MEM_LINES);
    localparam int COUNT_BITS = $clog2(MEM_LATENCY + 1);
    localparam int WORDS_PER_LINE = dcache_pkg::LINE_BITS / dcache_pkg::WORD_BITS;

    dcache_pkg::line_t mem [MEM_LINES];

    logic active;
    logic wait_low;
    logic last_write;
    logic [COUNT_BITS-1:0] count;
    logic [INDEX_BITS-1:0] index;
    logic released;
    logic start;

    // Line address wraps at the memory depth
    assign index = bus.addr[dcache_pkg::OFFSET_BITS +: INDEX_BITS];

    // The enable of the last access must fall before a new one starts
    assign released = !wait_low || !(last_write ? bus.write_en : bus.read_en);
    assign start = !active && released && (bus.read_en || bus.write_en);

    assign bus.ready = active && (count == '0);
    assign bus.read_data = mem[index];

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            wait_low <= 1'b0;
            last_write <= 1'b0;
            count <= '0;
            for (int i = 0; i < MEM_LINES; i++) begin
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    mem[i][w * dcache_pkg::WORD_BITS +: dcache_pkg::WORD_BITS] <=
                        dcache_pkg::init_word(dcache_pkg::addr_t'(
                            i * dcache_pkg::LINE_BYTES + w * (dcache_pkg::WORD_BITS / 8)));
                end
            end
        end else if (!active) begin
            if (released) begin
                wait_low <= 1'b0;
            end
            if (start) begin
                active <= 1'b1;
                last_write <= bus.write_en;
                count <= COUNT_BITS'(MEM_LATENCY - 1);
            end
        end else if (count != '0) begin
            count <= count - 1'b1;
        end else begin
            // Ready cycle
            active <= 1'b0;
            wait_low <= 1'b1;
            if (bus.write_en) begin
                mem[index] <= bus.write_data;
            end
        end
    end

    a_ready_with_enable: assert property (
        @(posedge clk) disable iff (reset)
        bus.ready |-> (bus.read_en || bus.write_en)
    );

endmodule

// ==== hdl/mem_bus_if.sv ====
interface mem_bus_if;

    // Requests, held by the cache until ready
    logic read_en;
    logic write_en;
    dcache_pkg::addr_t addr;
    dcache_pkg::line_t write_data;

    // Response, valid in the ready cycle
    dcache_pkg::line_t read_data;
    logic ready;

    modport cache (
        output read_en,
        output write_en,
        output addr,
        output write_data,
        input read_data,
        input ready
    );

    modport memory (
        input read_en,
        input write_en,
        input addr,
        input write_data,
        output read_data,
        output ready
    );

endinterface

// ==== sim/dcache_checker.sv ====
module dcache_checker #(
    parameter int NUM_SETS = 2,
    parameter int MEM_LINES = 64
) (
    input logic clk,
    input logic reset,
    input dcache_pkg::addr_t addr,
    input dcache_pkg::word_t write_data,
    input logic read_en,
    input logic write_en,
    input dcache_pkg::funct3_t funct3,
    input dcache_pkg::word_t read_data,
    input logic busy,
    input logic hit,
    input int entry_idx,
    output int pass_count,
    output int fail_count
);

    // Byte image of the whole backing memory
    localparam int SHADOW_BYTES = MEM_LINES * 16;

    logic [7:0] shadow [SHADOW_BYTES];
    int tag_model [NUM_SETS][2];
    logic valid_model [NUM_SETS][2];
    logic lru_model [NUM_SETS];

    logic in_progress;
    logic first_hit;
    logic entry_ok;

    task automatic seed_shadow;
        dcache_pkg::word_t w;
        for (int i = 0; i < SHADOW_BYTES; i++) begin
            // Word address XOR the reset pattern, little endian bytes
            w = (i & ~3) ^ 32'ha5a5_0000;
            shadow[i] = w[8 * (i % 4) +: 8];
        end
    endtask

    function automatic logic [7:0] shadow_byte(dcache_pkg::addr_t a);
        return shadow[a % SHADOW_BYTES];
    endfunction

    function automatic dcache_pkg::word_t expected_load(dcache_pkg::addr_t a,
                                                        dcache_pkg::funct3_t f3);
        logic [7:0] b;
        logic [15:0] h;
        b = shadow_byte(a);
        h = {shadow_byte(a + 1), b};
        case (f3)
            dcache_pkg::F3_B: return {{24{b[7]}}, b};
            dcache_pkg::F3_BU: return {24'b0, b};
            dcache_pkg::F3_H: return {{16{h[15]}}, h};
            dcache_pkg::F3_HU: return {16'b0, h};
            default: return {shadow_byte(a + 3), shadow_byte(a + 2), h};
        endcase
    endfunction

    task automatic apply_store(dcache_pkg::addr_t a, dcache_pkg::funct3_t f3,
                               dcache_pkg::word_t d);
        int n;
        n = (f3 == dcache_pkg::F3_B) ? 1 : (f3 == dcache_pkg::F3_H) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            shadow[(a + k) % SHADOW_BYTES] = d[8 * k +: 8];
        end
    endtask

    function automatic int set_of(dcache_pkg::addr_t a);
        return int'(a >> 4) % NUM_SETS;
    endfunction

    function automatic int tag_of(dcache_pkg::addr_t a);
        return int'(a >> 4) / NUM_SETS;
    endfunction

    // Way holding the line, or -1 on a miss
    function automatic int find_way(dcache_pkg::addr_t a);
        for (int w = 0; w < 2; w++) begin
            if (valid_model[set_of(a)][w] && tag_model[set_of(a)][w] == tag_of(a)) begin
                return w;
            end
        end
        return -1;
    endfunction

    always @(posedge clk) begin
        int set;
        int way;
        dcache_pkg::word_t expected;
        if (reset) begin
            seed_shadow();
            for (int s = 0; s < NUM_SETS; s++) begin
                lru_model[s] = 1'b0;
                valid_model[s][0] = 1'b0;
                valid_model[s][1] = 1'b0;
            end
            in_progress = 1'b0;
            pass_count = 0;
            fail_count = 0;
        end else if (read_en || write_en) begin
            set = set_of(addr);
            way = find_way(addr);
            // Hit prediction only in the first cycle of a request
            if (!in_progress) begin
                first_hit = (way >= 0);
                entry_ok = 1'b1;
                if (hit !== first_hit || busy !== !first_hit) begin
                    $display("** Error at %0t: entry %0d expected hit %b busy %b, got hit %b busy %b",
                             $time, entry_idx, first_hit, !first_hit, hit, busy);
                    entry_ok = 1'b0;
                end
            end
            if (busy === 1'b0) begin
                // Refill went into the way the LRU bit pointed at
                if (way < 0) begin
                    way = lru_model[set];
                    tag_model[set][way] = tag_of(addr);
                    valid_model[set][way] = 1'b1;
                end
                lru_model[set] = (way == 0);
                if (write_en) begin
                    apply_store(addr, funct3, write_data);
                end else begin
                    expected = expected_load(addr, funct3);
                    if (read_data !== expected) begin
                        $display("** Error at %0t: entry %0d load %h funct3 %0d got %h, expected %h",
                                 $time, entry_idx, addr, funct3, read_data, expected);
                        entry_ok = 1'b0;
                    end
                end
                $display("entry %0d: %s addr %h funct3 %0d %s, %s", entry_idx,
                         write_en ? "store" : "load", addr, funct3,
                         first_hit ? "hit" : "miss", entry_ok ? "ok" : "mismatch");
                if (entry_ok) begin
                    pass_count++;
                end else begin
                    fail_count++;
                end
                in_progress = 1'b0;
            end else begin
                in_progress = 1'b1;
            end
        end
    end

endmodule

// ==== sim/tb_dcache_subsystem.sv ====
module tb_dcache_subsystem;

    localparam int NUM_SETS = 2;
    localparam int MEM_LATENCY = 3;
    localparam int MEM_LINES = 64;

    localparam logic LOAD = 1'b0;
    localparam logic STORE = 1'b1;

    typedef struct packed {
        logic is_store;
        dcache_pkg::funct3_t f3;
        dcache_pkg::addr_t addr;
        dcache_pkg::word_t data;
        logic rand_data;
    } stim_t;

    logic clk;
    logic reset;
    dcache_pkg::addr_t addr;
    dcache_pkg::word_t write_data;
    logic read_en;
    logic write_en;
    dcache_pkg::funct3_t funct3;
    dcache_pkg::word_t read_data;
    logic busy;
    logic hit;

    int entry_idx;
    int pass_count;
    int fail_count;
    int timeout_cycles;
    integer seed;
    stim_t stim_q[$];

    dcache_subsystem #(
        .NUM_SETS(NUM_SETS),
        .MEM_LATENCY(MEM_LATENCY),
        .MEM_LINES(MEM_LINES)
    ) dcache_subsystem_i (
        .clk(clk),
        .reset(reset),
        .addr(addr),
        .write_data(write_data),
        .read_en(read_en),
        .write_en(write_en),
        .funct3(funct3),
        .read_data(read_data),
        .busy(busy),
        .hit(hit)
    );

    dcache_checker #(
        .NUM_SETS(NUM_SETS),
        .MEM_LINES(MEM_LINES)
    ) checker_i (
        .clk(clk),
        .reset(reset),
        .addr(addr),
        .write_data(write_data),
        .read_en(read_en),
        .write_en(write_en),
        .funct3(funct3),
        .read_data(read_data),
        .busy(busy),
        .hit(hit),
        .entry_idx(entry_idx),
        .pass_count(pass_count),
        .fail_count(fail_count)
    );

    task automatic add_stim(logic is_store, dcache_pkg::funct3_t f3, dcache_pkg::addr_t a,
                            dcache_pkg::word_t d, logic rand_data);
        stim_t e;
        e.is_store = is_store;
        e.f3 = f3;
        e.addr = a;
        e.data = d;
        e.rand_data = rand_data;
        stim_q.push_back(e);
    endtask

    task automatic build_table;
        // Cold miss, then hits on the same line with sign and zero extension
        add_stim(LOAD, dcache_pkg::F3_W, 32'h000, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_W, 32'h004, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_B, 32'h002, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_BU, 32'h002, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_H, 32'h002, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_HU, 32'h002, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_B, 32'h003, 0, 0);
        // Store hits at several offsets, then read back
        add_stim(STORE, dcache_pkg::F3_B, 32'h009, 0, 1);
        add_stim(STORE, dcache_pkg::F3_H, 32'h00e, 32'h0000_8123, 0);
        add_stim(STORE, dcache_pkg::F3_W, 32'h004, 0, 1);
        add_stim(LOAD, dcache_pkg::F3_W, 32'h008, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_W, 32'h00c, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_W, 32'h004, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_B, 32'h009, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_H, 32'h00e, 0, 0);
        // Store miss allocates the line
        add_stim(STORE, dcache_pkg::F3_W, 32'h010, 0, 1);
        add_stim(LOAD, dcache_pkg::F3_W, 32'h010, 0, 0);
        add_stim(STORE, dcache_pkg::F3_B, 32'h013, 32'h0000_00f0, 0);
        add_stim(LOAD, dcache_pkg::F3_BU, 32'h013, 0, 0);
        // Three lines in set 0, dirty victims go back to memory
        add_stim(STORE, dcache_pkg::F3_W, 32'h020, 0, 1);
        add_stim(STORE, dcache_pkg::F3_W, 32'h040, 0, 1);
        add_stim(LOAD, dcache_pkg::F3_W, 32'h008, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_W, 32'h004, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_W, 32'h020, 0, 0);
        // LRU in set 1 with lines A, B, C
        add_stim(LOAD, dcache_pkg::F3_W, 32'h030, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_W, 32'h050, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_W, 32'h030, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_W, 32'h070, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_W, 32'h030, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_W, 32'h050, 0, 0);
        add_stim(LOAD, dcache_pkg::F3_W, 32'h010, 0, 0);
    endtask

    // Drive one entry and hold it until the cycle without busy
    task automatic apply_entry(stim_t e, int idx);
        dcache_pkg::word_t d;
        d = e.rand_data ? dcache_pkg::word_t'($random(seed)) : e.data;
        addr <= e.addr;
        write_data <= d;
        funct3 <= e.f3;
        read_en <= !e.is_store;
        write_en <= e.is_store;
        entry_idx <= idx;
        @(posedge clk);
        while (busy) begin
            @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        seed = 32'hefe70ff9;
        build_table();
        reset = 1'b1;
        addr = '0;
        write_data = '0;
        read_en = 1'b0;
        write_en = 1'b0;
        funct3 = dcache_pkg::F3_W;
        entry_idx = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < stim_q.size(); i++) begin
            apply_entry(stim_q[i], i);
        end
        read_en <= 1'b0;
        write_en <= 1'b0;
        repeat (2) @(posedge clk);
        $display("Results: %0d passed, %0d failed of %0d entries",
                 pass_count, fail_count, stim_q.size());
        if (fail_count == 0 && pass_count == stim_q.size()) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog sized for a dirty miss on every entry
    initial begin
        repeat (2) @(posedge clk);
        timeout_cycles = stim_q.size() * (2 * MEM_LATENCY + 6) + 20;
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the cache did not finish all requests within %0d cycles",
                 timeout_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
